//--- camera_pkg.sv
`default_nettype none

package camera_pkg;

   // rgb565 pixel
   // red in [15:11], green in [10:5], blue in [4:0]
   typedef logic [15:0] pixel_t;

   // raster coordinates
   // 9 bits covers 320 columns
   typedef logic [8:0] hcount_t;
   // 8 bits covers 180 lines
   typedef logic [7:0] vcount_t;

   // inclusive cr window for the pink marker
   localparam logic [7:0] CR_LOWER = 8'd160;
   localparam logic [7:0] CR_UPPER = 8'd240;

   // byte pairing in the reconstructor
   // the high byte always comes first
   typedef enum logic {
      PHASE_FIRST,
      PHASE_SECOND
   } byte_phase_e;

   // 8n1 transmitter states
   typedef enum logic [1:0] {
      UART_IDLE,
      UART_START,
      UART_DATA,
      UART_STOP
   } uart_state_e;

endpackage

`default_nettype wire

//--- pixel_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pixel_if import camera_pkg::*; ();

   // one-cycle strobe, no back-pressure
   logic    valid;
   // coordinates and colour only meaningful with valid
   hcount_t hcount;
   vcount_t vcount;
   pixel_t  pixel;

   modport source (output valid, output hcount, output vcount, output pixel);
   modport sink   (input valid, input hcount, input vcount, input pixel);

endinterface

`default_nettype wire

//--- pixel_reconstruct.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_reconstruct import camera_pkg::*; (
   input  logic       clk_camera,
   input  logic       sys_rst_camera,
   input  logic       cam_pclk_i,
   input  logic       cam_hsync_i,
   input  logic       cam_vsync_i,
   input  logic [7:0] cam_d_i,
   pixel_if.source    cam_px
);

   // two-flop synchronisers, [1] is the safe copy
   logic [1:0]  pclk_sync;
   logic [1:0]  hsync_sync;
   logic [1:0]  vsync_sync;
   logic [7:0]  d_s1;
   logic [7:0]  d_s2;
   // previous synced values for edge detection
   logic        pclk_prev;
   logic        hsync_prev;
   logic        vsync_prev;
   logic        pclk_rise;
   logic        hsync_fall;
   logic        vsync_fall;
   // registered edge events
   logic        byte_stb;
   logic        hs_fall_q;
   logic        vs_fall_q;
   logic [7:0]  byte_q;
   // pairing and raster position
   byte_phase_e phase;
   logic [7:0]  hi_byte;
   logic        pair_stb;
   pixel_t      pair_pix;
   hcount_t     pair_h;
   vcount_t     pair_v;
   hcount_t     h_cnt;
   vcount_t     v_cnt;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_sync  <= '0;
         hsync_sync <= '0;
         vsync_sync <= '0;
         pclk_prev  <= 1'b0;
         hsync_prev <= 1'b0;
         vsync_prev <= 1'b0;
      end else begin
         pclk_sync  <= {pclk_sync[0], cam_pclk_i};
         hsync_sync <= {hsync_sync[0], cam_hsync_i};
         vsync_sync <= {vsync_sync[0], cam_vsync_i};
         pclk_prev  <= pclk_sync[1];
         hsync_prev <= hsync_sync[1];
         vsync_prev <= vsync_sync[1];
      end
   end

   // data follows the same two flops as pclk
   always_ff @(posedge clk_camera) begin
      d_s1   <= cam_d_i;
      d_s2   <= d_s1;
      byte_q <= d_s2;
   end

   assign pclk_rise  = pclk_sync[1] & ~pclk_prev;
   assign hsync_fall = ~hsync_sync[1] & hsync_prev;
   assign vsync_fall = ~vsync_sync[1] & vsync_prev;

   // bytes only count inside an active line of an active frame
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         byte_stb  <= 1'b0;
         hs_fall_q <= 1'b0;
         vs_fall_q <= 1'b0;
      end else begin
         byte_stb  <= pclk_rise & hsync_sync[1] & vsync_sync[1];
         hs_fall_q <= hsync_fall;
         vs_fall_q <= vsync_fall;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         phase    <= PHASE_FIRST;
         pair_stb <= 1'b0;
         h_cnt    <= '0;
         v_cnt    <= '0;
      end else begin
         pair_stb <= 1'b0;
         if (vs_fall_q) begin
            // end of frame
            phase <= PHASE_FIRST;
            h_cnt <= '0;
            v_cnt <= '0;
         end else if (hs_fall_q) begin
            // end of line, realign on the high byte
            phase <= PHASE_FIRST;
            h_cnt <= '0;
            v_cnt <= v_cnt + 1'b1;
         end else if (byte_stb) begin
            if (phase == PHASE_FIRST) begin
               phase <= PHASE_SECOND;
            end else begin
               phase    <= PHASE_FIRST;
               pair_stb <= 1'b1;
               h_cnt    <= h_cnt + 1'b1;
            end
         end
      end
   end

   // pixel assembly, position taken before the count moves on
   always_ff @(posedge clk_camera) begin
      if (byte_stb && phase == PHASE_FIRST) begin
         hi_byte <= byte_q;
      end
      if (byte_stb && phase == PHASE_SECOND) begin
         pair_pix <= {hi_byte, byte_q};
         pair_h   <= h_cnt;
         pair_v   <= v_cnt;
      end
   end

   // output stage
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         cam_px.valid <= 1'b0;
      end else begin
         cam_px.valid <= pair_stb;
      end
   end

   always_ff @(posedge clk_camera) begin
      cam_px.pixel  <= pair_pix;
      cam_px.hcount <= pair_h;
      cam_px.vcount <= pair_v;
   end

endmodule

`default_nettype wire

//--- chroma_mask.sv
`timescale 1ns/1ps
`default_nettype none

module chroma_mask import camera_pkg::*; (
   input  logic    clk_camera,
   input  logic    sys_rst_camera,
   pixel_if.sink   cam_px,
   pixel_if.source mask_px,
   output logic    mask_o
);

   // stage 1, widened channels and delayed stream
   logic              s1_valid;
   hcount_t           s1_h;
   vcount_t           s1_v;
   pixel_t            s1_pix;
   logic [7:0]        r8;
   logic [7:0]        g8;
   logic [7:0]        b8;
   // cr arithmetic
   logic signed [17:0] cr_sum;
   logic signed [17:0] cr_wide;
   logic [7:0]        cr;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= cam_px.valid;
      end
   end

   // 565 to 888 by zero fill
   always_ff @(posedge clk_camera) begin
      r8     <= {cam_px.pixel[15:11], 3'b000};
      g8     <= {cam_px.pixel[10:5], 2'b00};
      b8     <= {cam_px.pixel[4:0], 3'b000};
      s1_h   <= cam_px.hcount;
      s1_v   <= cam_px.vcount;
      s1_pix <= cam_px.pixel;
   end

   // cr = 128 + floor((128r - 107g - 21b) / 256)
   always_comb begin
      cr_sum = $signed({10'b0, r8}) * 18'sd128
             - $signed({10'b0, g8}) * 18'sd107
             - $signed({10'b0, b8}) * 18'sd21;
      // arithmetic shift floors toward minus infinity
      cr_wide = (cr_sum >>> 8) + 18'sd128;
      if (cr_wide < 18'sd0) begin
         cr = 8'd0;
      end else if (cr_wide > 18'sd255) begin
         cr = 8'd255;
      end else begin
         cr = cr_wide[7:0];
      end
   end

   // stage 2, window test
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         mask_px.valid <= 1'b0;
         mask_o        <= 1'b0;
      end else begin
         mask_px.valid <= s1_valid;
         mask_o        <= s1_valid && (cr >= CR_LOWER) && (cr <= CR_UPPER);
      end
   end

   always_ff @(posedge clk_camera) begin
      mask_px.hcount <= s1_h;
      mask_px.vcount <= s1_v;
      mask_px.pixel  <= s1_pix;
   end

endmodule

`default_nettype wire

//--- center_of_mass.sv
`timescale 1ns/1ps
`default_nettype none

module center_of_mass import camera_pkg::*; #(
   parameter int FRAME_WIDTH  = 320,
   parameter int FRAME_HEIGHT = 180
) (
   input  logic    clk_camera,
   input  logic    sys_rst_camera,
   pixel_if.sink   mask_px,
   input  logic    mask_i,
   output hcount_t com_x_o,
   output vcount_t com_y_o,
   output logic    com_valid_o
);

   // pixel count and sum widths
   localparam int NPIX   = FRAME_WIDTH * FRAME_HEIGHT;
   localparam int CNT_W  = $clog2(NPIX + 1);
   // x sums need 9 more bits than the count, y sums fit too
   localparam int DIV_W  = CNT_W + 9;
   localparam int STEP_W = $clog2(DIV_W + 1);

   logic               hit;
   logic               frame_end;
   logic [DIV_W-1:0]   x_sum;
   logic [DIV_W-1:0]   y_sum;
   logic [CNT_W-1:0]   pix_cnt;
   logic [DIV_W-1:0]   x_sum_next;
   logic [DIV_W-1:0]   y_sum_next;
   logic [CNT_W-1:0]   pix_cnt_next;
   // divider state
   logic               busy;
   logic [STEP_W-1:0]  step;
   logic [DIV_W-1:0]   divisor;
   logic [DIV_W-1:0]   x_rem;
   logic [DIV_W-1:0]   x_quo;
   logic [DIV_W-1:0]   y_rem;
   logic [DIV_W-1:0]   y_quo;
   logic [2*DIV_W-1:0] x_step;
   logic [2*DIV_W-1:0] y_step;

   // one restoring step, returns {remainder, quotient}
   // quo starts as the dividend and fills with quotient bits
   function automatic logic [2*DIV_W-1:0] div_step(
      input logic [DIV_W-1:0] rem,
      input logic [DIV_W-1:0] quo,
      input logic [DIV_W-1:0] den
   );
      logic [DIV_W-1:0] trial;
      trial = {rem[DIV_W-2:0], quo[DIV_W-1]};
      if (trial >= den) begin
         div_step = {trial - den, quo[DIV_W-2:0], 1'b1};
      end else begin
         div_step = {trial, quo[DIV_W-2:0], 1'b0};
      end
   endfunction

   assign hit       = mask_px.valid & mask_i;
   // last pixel of the frame closes it
   assign frame_end = mask_px.valid
                   && (mask_px.hcount == FRAME_WIDTH - 1)
                   && (mask_px.vcount == FRAME_HEIGHT - 1);

   // running sums including the current pixel
   assign x_sum_next   = x_sum + (hit ? DIV_W'(mask_px.hcount) : '0);
   assign y_sum_next   = y_sum + (hit ? DIV_W'(mask_px.vcount) : '0);
   assign pix_cnt_next = pix_cnt + CNT_W'(hit);

   assign x_step = div_step(x_rem, x_quo, divisor);
   assign y_step = div_step(y_rem, y_quo, divisor);

   // accumulators restart at every frame boundary
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera || frame_end) begin
         x_sum   <= '0;
         y_sum   <= '0;
         pix_cnt <= '0;
      end else begin
         x_sum   <= x_sum_next;
         y_sum   <= y_sum_next;
         pix_cnt <= pix_cnt_next;
      end
   end

   // start only when idle and something was masked
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         busy        <= 1'b0;
         step        <= '0;
         com_valid_o <= 1'b0;
         com_x_o     <= '0;
         com_y_o     <= '0;
      end else begin
         com_valid_o <= 1'b0;
         if (!busy) begin
            if (frame_end && pix_cnt_next != '0) begin
               busy <= 1'b1;
               step <= '0;
            end
         end else if (step == DIV_W) begin
            // all quotient bits in place
            busy        <= 1'b0;
            com_valid_o <= 1'b1;
            com_x_o     <= x_quo[8:0];
            com_y_o     <= y_quo[7:0];
         end else begin
            step <= step + 1'b1;
         end
      end
   end

   // operands load while idle, one bit per cycle while busy
   always_ff @(posedge clk_camera) begin
      if (!busy) begin
         x_rem   <= '0;
         x_quo   <= x_sum_next;
         y_rem   <= '0;
         y_quo   <= y_sum_next;
         divisor <= {{(DIV_W - CNT_W){1'b0}}, pix_cnt_next};
      end else if (step != DIV_W) begin
         {x_rem, x_quo} <= x_step;
         {y_rem, y_quo} <= y_step;
      end
   end

endmodule

`default_nettype wire

//--- crosshair_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module crosshair_overlay import camera_pkg::*; (
   input  logic    clk_camera,
   input  logic    sys_rst_camera,
   pixel_if.sink   mask_px,
   input  logic    mask_i,
   input  hcount_t com_x_i,
   input  vcount_t com_y_i,
   output logic    out_valid_o,
   output hcount_t out_hcount_o,
   output vcount_t out_vcount_o,
   output pixel_t  out_pixel_o
);

   logic   on_line;
   pixel_t view_pix;

   // crosshair against the centre held right now
   assign on_line = (mask_px.hcount == com_x_i) || (mask_px.vcount == com_y_i);

   always_comb begin
      if (on_line) begin
         // white line
         view_pix = '1;
      end else if (mask_i) begin
         // masked pixels keep their colour
         view_pix = mask_px.pixel;
      end else begin
         view_pix = '0;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= mask_px.valid;
      end
   end

   // one stage, coordinates ride along
   always_ff @(posedge clk_camera) begin
      out_hcount_o <= mask_px.hcount;
      out_vcount_o <= mask_px.vcount;
      out_pixel_o  <= view_pix;
   end

endmodule

`default_nettype wire

//--- com_uart_report.sv
`timescale 1ns/1ps
`default_nettype none

module com_uart_report import camera_pkg::*; #(
   parameter int CLKS_PER_BIT = 868
) (
   input  logic    clk_camera,
   input  logic    sys_rst_camera,
   input  hcount_t com_x_i,
   input  vcount_t com_y_i,
   input  logic    com_valid_i,
   output logic    uart_tx_o
);

   localparam int BAUD_W = $clog2(CLKS_PER_BIT);

   uart_state_e       state;
   logic [BAUD_W-1:0] baud_cnt;
   logic [2:0]        bit_idx;
   logic [1:0]        byte_idx;
   // three bytes, the one in flight sits in the low bits
   logic [23:0]       frame;
   logic              bit_done;

   assign bit_done = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state     <= UART_IDLE;
         baud_cnt  <= '0;
         bit_idx   <= '0;
         byte_idx  <= '0;
         uart_tx_o <= 1'b1;
      end else begin
         case (state)
            UART_IDLE: begin
               uart_tx_o <= 1'b1;
               // strobes while busy are dropped
               if (com_valid_i) begin
                  state     <= UART_START;
                  baud_cnt  <= '0;
                  byte_idx  <= '0;
                  uart_tx_o <= 1'b0;
               end
            end
            UART_START: begin
               if (bit_done) begin
                  baud_cnt  <= '0;
                  bit_idx   <= '0;
                  state     <= UART_DATA;
                  uart_tx_o <= frame[0];
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            UART_DATA: begin
               if (bit_done) begin
                  baud_cnt <= '0;
                  if (bit_idx == 3'd7) begin
                     state     <= UART_STOP;
                     uart_tx_o <= 1'b1;
                  end else begin
                     bit_idx   <= bit_idx + 1'b1;
                     // next bit after the shift below
                     uart_tx_o <= frame[1];
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: begin
               // stop bit, then next byte or back to idle
               if (bit_done) begin
                  baud_cnt <= '0;
                  if (byte_idx == 2'd2) begin
                     state <= UART_IDLE;
                  end else begin
                     byte_idx  <= byte_idx + 1'b1;
                     state     <= UART_START;
                     uart_tx_o <= 1'b0;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // lsb first, x msb byte goes out first, y last
   always_ff @(posedge clk_camera) begin
      if (state == UART_IDLE && com_valid_i) begin
         frame <= {com_y_i, com_x_i[7:0], 7'b0, com_x_i[8]};
      end else if (state == UART_DATA && bit_done) begin
         frame <= {1'b0, frame[23:1]};
      end
   end

endmodule

`default_nettype wire

//--- tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module tracker_top #(
   parameter int FRAME_WIDTH  = 320,
   parameter int FRAME_HEIGHT = 180,
   // 200 mhz camera clock at 230400 baud
   parameter int CLKS_PER_BIT = 868
) (
   input  logic        clk_camera,
   input  logic        sys_rst_camera,
   // raw camera bus
   input  logic        cam_pclk_i,
   input  logic        cam_hsync_i,
   input  logic        cam_vsync_i,
   input  logic [7:0]  cam_d_i,
   // masked view with crosshair
   output logic        out_valid_o,
   output logic [8:0]  out_hcount_o,
   output logic [7:0]  out_vcount_o,
   output logic [15:0] out_pixel_o,
   // centre of mass
   output logic [8:0]  com_x_o,
   output logic [7:0]  com_y_o,
   output logic        com_valid_o,
   output logic        uart_tx_o
);

   logic mask;

   // camera pixels, then masked pixels two cycles later
   pixel_if cam_px ();
   pixel_if mask_px ();

   pixel_reconstruct pixel_reconstruct_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .cam_d_i        (cam_d_i),
      .cam_px         (cam_px.source)
   );

   chroma_mask chroma_mask_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_px         (cam_px.sink),
      .mask_px        (mask_px.source),
      .mask_o         (mask)
   );

   center_of_mass #(
      .FRAME_WIDTH  (FRAME_WIDTH),
      .FRAME_HEIGHT (FRAME_HEIGHT)
   ) center_of_mass_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_px        (mask_px.sink),
      .mask_i         (mask),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o),
      .com_valid_o    (com_valid_o)
   );

   // overlay uses the held centre from the last finished frame
   crosshair_overlay crosshair_overlay_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_px        (mask_px.sink),
      .mask_i         (mask),
      .com_x_i        (com_x_o),
      .com_y_i        (com_y_o),
      .out_valid_o    (out_valid_o),
      .out_hcount_o   (out_hcount_o),
      .out_vcount_o   (out_vcount_o),
      .out_pixel_o    (out_pixel_o)
   );

   com_uart_report #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) com_uart_report_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .com_x_i        (com_x_o),
      .com_y_i        (com_y_o),
      .com_valid_i    (com_valid_o),
      .uart_tx_o      (uart_tx_o)
   );

endmodule

`default_nettype wire

//--- tb_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tracker import camera_pkg::*; ();

   // small frame keeps runs short
   localparam int FRAME_WIDTH  = 8;
   localparam int FRAME_HEIGHT = 4;
   localparam int CLKS_PER_BIT = 8;
   localparam int NPIX         = FRAME_WIDTH * FRAME_HEIGHT;
   // wait limits in clk_camera cycles
   localparam int PIX_TIMEOUT  = 200;
   localparam int COM_TIMEOUT  = 100;
   localparam int IDLE_TIMEOUT = 3000;
   localparam int RX_TIMEOUT   = 50 * CLKS_PER_BIT;

   logic        clk_camera = 1'b0;
   logic        sys_rst_camera;
   logic        cam_pclk_i;
   logic        cam_hsync_i;
   logic        cam_vsync_i;
   logic [7:0]  cam_d_i;
   logic        out_valid_o;
   hcount_t     out_hcount_o;
   vcount_t     out_vcount_o;
   pixel_t      out_pixel_o;
   hcount_t     com_x_o;
   vcount_t     com_y_o;
   logic        com_valid_o;
   logic        uart_tx_o;

   // stimulus frame in raster order
   pixel_t      frame_pix [0:NPIX-1];
   // reference centre, starts at the reset value
   hcount_t     model_com_x;
   vcount_t     model_com_y;
   hcount_t     got_com_x;
   vcount_t     got_com_y;
   logic [31:0] lfsr_state;
   logic [7:0]  rx_q [$];
   int          errors;
   int          err_mark;
   int          tests_run;
   int          tests_failed;
   string       test_name;

   always #5 clk_camera = ~clk_camera;

   tracker_top #(
      .FRAME_WIDTH  (FRAME_WIDTH),
      .FRAME_HEIGHT (FRAME_HEIGHT),
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) tracker_top_i (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .cam_d_i        (cam_d_i),
      .out_valid_o    (out_valid_o),
      .out_hcount_o   (out_hcount_o),
      .out_vcount_o   (out_vcount_o),
      .out_pixel_o    (out_pixel_o),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o),
      .com_valid_o    (com_valid_o),
      .uart_tx_o      (uart_tx_o)
   );

   // galois lfsr, one step per bit taken
   function automatic logic lfsr_next_bit();
      logic out_bit;
      out_bit = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
         lfsr_state = lfsr_state ^ 32'hD000_0001;
      end
      return out_bit;
   endfunction

   function automatic pixel_t random_pixel();
      pixel_t p;
      for (int i = 0; i < 16; i++) begin
         p = {p[14:0], lfsr_next_bit()};
      end
      return p;
   endfunction

   // cr from the zero-filled 888 channels, floored and clamped
   function automatic int cr_value(input pixel_t p);
      int r8;
      int g8;
      int b8;
      int s;
      int q;
      r8 = int'(p[15:11]) * 8;
      g8 = int'(p[10:5]) * 4;
      b8 = int'(p[4:0]) * 8;
      s = 128 * r8 - 107 * g8 - 21 * b8;
      q = s / 256;
      // integer divide truncates, so fix up negatives
      if (s < 0 && (s % 256) != 0) begin
         q = q - 1;
      end
      q = q + 128;
      if (q < 0) begin
         q = 0;
      end else if (q > 255) begin
         q = 255;
      end
      return q;
   endfunction

   function automatic logic in_window(input pixel_t p);
      int cr;
      cr = cr_value(p);
      return (cr >= int'(CR_LOWER)) && (cr <= int'(CR_UPPER));
   endfunction

   // crosshair wins, then masked colour, else black
   function automatic pixel_t view_pixel(input pixel_t p, input hcount_t h,
                                         input vcount_t v, input hcount_t cx,
                                         input vcount_t cy);
      if (h == cx || v == cy) begin
         return 16'hFFFF;
      end else if (in_window(p)) begin
         return p;
      end
      return 16'h0000;
   endfunction

   task automatic pixel_check(input string name, input pixel_t got, input pixel_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic hcount_check(input string name, input hcount_t got, input hcount_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic vcount_check(input string name, input vcount_t got, input vcount_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic byte_check(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic level_check(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_mark = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == err_mark) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, errors - err_mark);
      end
   endtask

   // one byte, pclk low for 2 cycles then high for 2
   task automatic send_byte(input logic [7:0] b);
      cam_d_i = b;
      cam_pclk_i = 1'b0;
      repeat (2) @(negedge clk_camera);
      cam_pclk_i = 1'b1;
      repeat (2) @(negedge clk_camera);
   endtask

   task automatic drive_frame();
      pixel_t p;
      @(negedge clk_camera);
      cam_vsync_i = 1'b1;
      repeat (4) @(negedge clk_camera);
      for (int y = 0; y < FRAME_HEIGHT; y++) begin
         cam_hsync_i = 1'b1;
         repeat (2) @(negedge clk_camera);
         for (int x = 0; x < FRAME_WIDTH; x++) begin
            p = frame_pix[y * FRAME_WIDTH + x];
            // high byte first
            send_byte(p[15:8]);
            send_byte(p[7:0]);
         end
         // falling hsync closes the line
         cam_pclk_i = 1'b0;
         cam_hsync_i = 1'b0;
         repeat (6) @(negedge clk_camera);
      end
      cam_vsync_i = 1'b0;
      repeat (8) @(negedge clk_camera);
   endtask

   // raster order check of every output pixel
   task automatic collect_frame(input hcount_t cx, input vcount_t cy);
      logic    seen;
      hcount_t eh;
      vcount_t ev;
      for (int idx = 0; idx < NPIX; idx++) begin
         seen = 1'b0;
         for (int n = 0; n < PIX_TIMEOUT && !seen; n++) begin
            @(negedge clk_camera);
            seen = out_valid_o;
         end
         if (!seen) begin
            errors++;
            $display("timeout: output pixel %0d of the frame never arrived", idx);
            break;
         end
         eh = hcount_t'(idx % FRAME_WIDTH);
         ev = vcount_t'(idx / FRAME_WIDTH);
         hcount_check("out_hcount_o", out_hcount_o, eh);
         vcount_check("out_vcount_o", out_vcount_o, ev);
         pixel_check("out_pixel_o", out_pixel_o, view_pixel(frame_pix[idx], eh, ev, cx, cy));
      end
   endtask

   // strobe expected only when something was masked
   task automatic await_result(input int hits, input hcount_t ex, input vcount_t ey);
      logic seen;
      seen = 1'b0;
      for (int n = 0; n < COM_TIMEOUT && !seen; n++) begin
         @(negedge clk_camera);
         if (com_valid_o) begin
            seen = 1'b1;
            got_com_x = com_x_o;
            got_com_y = com_y_o;
         end
      end
      if (hits > 0) begin
         if (!seen) begin
            errors++;
            $display("timeout: no centre of mass strobe after the frame");
         end else begin
            hcount_check("com_x_o", got_com_x, ex);
            vcount_check("com_y_o", got_com_y, ey);
         end
      end else begin
         if (seen) begin
            errors++;
            $display("centre of mass strobe seen for a frame with no masked pixels");
         end
         hcount_check("com_x_o", com_x_o, ex);
         vcount_check("com_y_o", com_y_o, ey);
      end
   endtask

   // drive frame_pix and check outputs against the reference
   task automatic run_frame();
      int      hits;
      int      sum_x;
      int      sum_y;
      hcount_t nx;
      vcount_t ny;
      hcount_t cx;
      vcount_t cy;
      hits = 0;
      sum_x = 0;
      sum_y = 0;
      for (int idx = 0; idx < NPIX; idx++) begin
         if (in_window(frame_pix[idx])) begin
            hits++;
            sum_x += idx % FRAME_WIDTH;
            sum_y += idx / FRAME_WIDTH;
         end
      end
      // overlay uses the previous frame's centre
      cx = model_com_x;
      cy = model_com_y;
      nx = cx;
      ny = cy;
      if (hits > 0) begin
         nx = hcount_t'(sum_x / hits);
         ny = vcount_t'(sum_y / hits);
      end
      fork
         drive_frame();
         begin
            collect_frame(cx, cy);
            await_result(hits, nx, ny);
         end
      join
      model_com_x = nx;
      model_com_y = ny;
   endtask

   task automatic fill_frame(input pixel_t colour);
      for (int idx = 0; idx < NPIX; idx++) begin
         frame_pix[idx] = colour;
      end
   endtask

   task automatic paint_rect(input int x0, input int x1, input int y0, input int y1,
                             input pixel_t colour);
      for (int y = y0; y <= y1; y++) begin
         for (int x = x0; x <= x1; x++) begin
            frame_pix[y * FRAME_WIDTH + x] = colour;
         end
      end
   endtask

   // 8n1, called once the start bit is seen low
   task automatic receive_uart_byte(output logic [7:0] b, output logic ok);
      ok = 1'b1;
      b = '0;
      repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk_camera);
      if (uart_tx_o !== 1'b0) begin
         ok = 1'b0;
         errors++;
         $display("uart start bit did not hold low to mid-bit at %0t", $time);
      end else begin
         for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk_camera);
            b[i] = uart_tx_o;
         end
         repeat (CLKS_PER_BIT) @(negedge clk_camera);
         if (uart_tx_o !== 1'b1) begin
            ok = 1'b0;
            errors++;
            $display("uart stop bit was low at %0t", $time);
         end
      end
   endtask

   // background receiver, queues every byte on the line
   initial begin : uart_monitor
      logic [7:0] b;
      logic       ok;
      forever begin
         @(negedge clk_camera);
         if (!sys_rst_camera && uart_tx_o === 1'b0) begin
            receive_uart_byte(b, ok);
            if (ok) begin
               rx_q.push_back(b);
            end
         end
      end
   end

   task automatic wait_uart_idle();
      int quiet;
      quiet = 0;
      for (int n = 0; n < IDLE_TIMEOUT && quiet < 12 * CLKS_PER_BIT; n++) begin
         @(negedge clk_camera);
         if (uart_tx_o === 1'b1) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
      if (quiet < 12 * CLKS_PER_BIT) begin
         errors++;
         $display("timeout: uart line never went quiet");
      end
   endtask

   task automatic reset_idle();
      begin_test("reset idle");
      for (int n = 0; n < 20; n++) begin
         @(negedge clk_camera);
         level_check("out_valid_o", out_valid_o, 1'b0);
         level_check("com_valid_o", com_valid_o, 1'b0);
         level_check("uart_tx_o", uart_tx_o, 1'b1);
      end
      end_test();
   endtask

   task automatic pink_frame();
      begin_test("all pink frame");
      fill_frame(16'hF81F);
      run_frame();
      end_test();
   endtask

   // green background, pink block at x 4..6, y 2..3
   task automatic rectangle_centre();
      begin_test("pink rectangle centre");
      fill_frame(16'h07E0);
      paint_rect(4, 6, 2, 3, 16'hF81F);
      run_frame();
      hcount_check("com_x_o", got_com_x, hcount_t'((4 + 6) / 2));
      vcount_check("com_y_o", got_com_y, vcount_t'((2 + 3) / 2));
      end_test();
   endtask

   task automatic random_frame();
      begin_test("lfsr frame");
      for (int idx = 0; idx < NPIX; idx++) begin
         frame_pix[idx] = random_pixel();
      end
      run_frame();
      end_test();
   endtask

   // block at x 6..7 on the last line
   task automatic uart_bytes();
      begin_test("uart report");
      wait_uart_idle();
      rx_q.delete();
      fill_frame(16'h0000);
      paint_rect(6, 7, 3, 3, 16'hF81F);
      run_frame();
      for (int n = 0; n < RX_TIMEOUT && rx_q.size() < 3; n++) begin
         @(negedge clk_camera);
      end
      if (rx_q.size() < 3) begin
         errors++;
         $display("timeout: only %0d of 3 uart bytes arrived", rx_q.size());
      end else begin
         byte_check("uart byte 0", rx_q[0], {7'b0, model_com_x[8]});
         byte_check("uart byte 1", rx_q[1], model_com_x[7:0]);
         byte_check("uart byte 2", rx_q[2], model_com_y);
      end
      end_test();
   endtask

   task automatic black_frame();
      begin_test("black frame");
      fill_frame(16'h0000);
      run_frame();
      end_test();
   endtask

   initial begin
      sys_rst_camera = 1'b1;
      cam_pclk_i = 1'b0;
      cam_hsync_i = 1'b0;
      cam_vsync_i = 1'b0;
      cam_d_i = 8'h00;
      lfsr_state = 32'd70991;
      model_com_x = '0;
      model_com_y = '0;
      got_com_x = '0;
      got_com_y = '0;
      errors = 0;
      err_mark = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (3) @(negedge clk_camera);
      sys_rst_camera = 1'b0;
      reset_idle();
      pink_frame();
      rectangle_centre();
      random_frame();
      uart_bytes();
      black_frame();
      $display("tests run %0d, tests with errors %0d, total errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
camera_pkg.sv
pixel_if.sv
pixel_reconstruct.sv
chroma_mask.sv
center_of_mass.sv
crosshair_overlay.sv
com_uart_report.sv
tracker_top.sv
tb_tracker.sv

//--- Makefile
SIM      = verilator
TOP      = tb_tracker
FILELIST = src.f
VFLAGS   = --binary --timing -Wno-fatal
BUILD    = obj_dir
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
